/* source/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // Fetch address and instruction word.
    localparam int PC_WIDTH = 32;
    localparam int INSTR_WIDTH = 32;

    // Fetch IDs index the PC file.
    localparam int FETCH_ID_WIDTH = 3;
    localparam int PC_FILE_ENTRIES = 1 << FETCH_ID_WIDTH;

    // Decode buffer slots, one credit each.
    localparam int FETCH_CREDITS = 4;
    localparam int CREDIT_WIDTH = 3;

    // Direct-mapped BTB, indexed by PC[5:2].
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_WIDTH = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - 2;

    // Pause after a WFI redirect.
    localparam int WFI_DELAY = 12;
    localparam int WFI_COUNT_WIDTH = $clog2(WFI_DELAY);

    typedef logic [PC_WIDTH-1:0] pcType;
    typedef logic [FETCH_ID_WIDTH-1:0] fetchIdType;
    typedef logic [CREDIT_WIDTH-1:0] creditType;
    typedef logic [WFI_COUNT_WIDTH-1:0] wfiCountType;

    // First fetch address after reset.
    localparam pcType RESET_PC = 32'h0000_0100;

endpackage

`default_nettype wire

/* source/branchTargetBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module branchTargetBuffer (
    input wire clk,
    input wire rst,

    input wire [fetchPkg::PC_WIDTH-1:0] lookupPc,
    output logic predTaken,
    output logic [fetchPkg::PC_WIDTH-1:0] predTarget,

    input wire updateValid,
    input wire [fetchPkg::PC_WIDTH-1:0] updateSrc,
    input wire [fetchPkg::PC_WIDTH-1:0] updateDst,
    input wire updateTaken
);

    logic [fetchPkg::BTB_ENTRIES-1:0] entryValid;
    logic [fetchPkg::BTB_TAG_WIDTH-1:0] entryTag [fetchPkg::BTB_ENTRIES];
    logic [fetchPkg::PC_WIDTH-3:0] entryTarget [fetchPkg::BTB_ENTRIES];

    logic [fetchPkg::BTB_INDEX_WIDTH-1:0] lookupIndex;
    logic [fetchPkg::BTB_TAG_WIDTH-1:0] lookupTag;
    logic [fetchPkg::BTB_INDEX_WIDTH-1:0] updateIndex;
    logic [fetchPkg::BTB_TAG_WIDTH-1:0] updateTag;
    logic updateHit;

    // Index from PC[5:2], tag from the bits above.
    assign lookupIndex = lookupPc[fetchPkg::BTB_INDEX_WIDTH+1:2];
    assign lookupTag = lookupPc[fetchPkg::PC_WIDTH-1:fetchPkg::BTB_INDEX_WIDTH+2];
    assign updateIndex = updateSrc[fetchPkg::BTB_INDEX_WIDTH+1:2];
    assign updateTag = updateSrc[fetchPkg::PC_WIDTH-1:fetchPkg::BTB_INDEX_WIDTH+2];

    assign predTaken = entryValid[lookupIndex] && (entryTag[lookupIndex] == lookupTag);
    assign predTarget = {entryTarget[lookupIndex], 2'b00};

    assign updateHit = entryValid[updateIndex] && (entryTag[updateIndex] == updateTag);

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end
        else if (updateValid) begin
            if (updateTaken) begin
                entryValid[updateIndex] <= 1'b1;
            end
            else if (updateHit) begin
                // Not-taken branch, drop its entry.
                entryValid[updateIndex] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (updateValid && updateTaken) begin
            entryTag[updateIndex] <= updateTag;
            entryTarget[updateIndex] <= updateDst[fetchPkg::PC_WIDTH-1:2];
        end
    end

endmodule

`default_nettype wire

/* source/imemTracker.sv */
`timescale 1ns/1ns
`default_nettype none

module imemTracker (
    input wire clk,
    input wire rst,

    input wire issueValid,
    input wire [fetchPkg::PC_WIDTH-1:0] issuePc,
    input wire [fetchPkg::FETCH_ID_WIDTH-1:0] issueFetchId,
    input wire issueInterrupt,
    input wire issuePredTaken,
    input wire [fetchPkg::PC_WIDTH-1:0] issuePredTarget,

    input wire squash,
    input wire [fetchPkg::INSTR_WIDTH-1:0] imemRespData,

    output logic outValid,
    output logic [fetchPkg::INSTR_WIDTH-1:0] outInstr,
    output logic [fetchPkg::PC_WIDTH-1:0] outPc,
    output logic [fetchPkg::FETCH_ID_WIDTH-1:0] outFetchId,
    output logic outPredTaken,
    output logic [fetchPkg::PC_WIDTH-1:0] outPredTarget,
    output logic outInterrupt
);

    logic pendValid;
    logic pendInterrupt;
    logic pendPredTaken;
    logic [fetchPkg::PC_WIDTH-1:0] pendPc;
    logic [fetchPkg::PC_WIDTH-1:0] pendPredTarget;
    logic [fetchPkg::FETCH_ID_WIDTH-1:0] pendFetchId;

    always_ff @(posedge clk) begin
        if (rst) begin
            pendValid <= 1'b0;
        end
        else begin
            pendValid <= issueValid && !squash;
        end
    end

    // Metadata of the request now at the memory.
    always_ff @(posedge clk) begin
        if (issueValid) begin
            pendPc <= issuePc;
            pendFetchId <= issueFetchId;
            pendInterrupt <= issueInterrupt;
            pendPredTaken <= issuePredTaken;
            pendPredTarget <= issuePredTarget;
        end
    end

    // A redirect this cycle kills the response in flight.
    assign outValid = pendValid && !squash;

    assign outInstr = pendInterrupt ? '0 : imemRespData;
    assign outPc = pendPc;
    assign outFetchId = pendFetchId;
    assign outPredTaken = pendPredTaken;
    assign outPredTarget = pendPredTarget;
    assign outInterrupt = pendInterrupt;

endmodule

`default_nettype wire

/* source/pcFile.sv */
`timescale 1ns/1ns
`default_nettype none

module pcFile (
    input wire clk,

    input wire writeValid,
    input wire [fetchPkg::FETCH_ID_WIDTH-1:0] writeId,
    input wire [fetchPkg::PC_WIDTH-1:0] writePc,

    input wire [fetchPkg::FETCH_ID_WIDTH-1:0] readId,
    output logic [fetchPkg::PC_WIDTH-1:0] readPc
);

    logic [fetchPkg::PC_WIDTH-1:0] entries [fetchPkg::PC_FILE_ENTRIES];

    always_ff @(posedge clk) begin
        if (writeValid) begin
            entries[writeId] <= writePc;
        end
    end

    // Backend read, no latency.
    assign readPc = entries[readId];

endmodule

`default_nettype wire

/* source/fetchSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchSequencer (
    input wire clk,
    input wire rst,

    input wire beRedirectValid,
    input wire [fetchPkg::PC_WIDTH-1:0] beRedirectPc,
    input wire decRedirectValid,
    input wire [fetchPkg::PC_WIDTH-1:0] decRedirectPc,
    input wire decRedirectWfi,

    input wire interruptPending,
    input wire creditReturn,

    input wire predTaken,
    input wire [fetchPkg::PC_WIDTH-1:0] predTarget,

    output logic [fetchPkg::PC_WIDTH-1:0] fetchPc,
    output logic issueValid,
    output logic [fetchPkg::FETCH_ID_WIDTH-1:0] issueFetchId,
    output logic issueInterrupt,
    output logic squash
);

    logic redirect;
    logic [fetchPkg::PC_WIDTH-1:0] redirectPc;
    fetchPkg::pcType pcNext;

    fetchPkg::fetchIdType fetchId;
    fetchPkg::creditType creditCount;
    fetchPkg::creditType creditNext;
    logic issuedLast;
    logic creditRefund;
    logic started;

    logic wfiActive;
    logic wfiStall;
    fetchPkg::wfiCountType wfiCount;
    logic intIssued;

    // Backend wins over decode.
    assign redirect = beRedirectValid || decRedirectValid;
    assign redirectPc = beRedirectValid ? beRedirectPc : decRedirectPc;
    assign squash = redirect;

    // An interrupt ends the WFI pause right away.
    assign wfiStall = wfiActive && !interruptPending;

    // Fetch starts one cycle after reset releases.
    assign issueValid = started && (creditCount != '0) && !redirect && !wfiStall
        && !intIssued;
    assign issueFetchId = fetchId;
    assign issueInterrupt = issueValid && interruptPending;

    // Credit comes back for a squashed request.
    assign creditRefund = redirect && issuedLast;

    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end
        else if (issueValid) begin
            pcNext = predTaken ? predTarget : fetchPc + fetchPkg::pcType'(4);
        end
        else begin
            pcNext = fetchPc;
        end
    end

    always_comb begin
        creditNext = creditCount;
        if (issueValid) begin
            creditNext = creditNext - fetchPkg::creditType'(1);
        end
        if (creditReturn) begin
            creditNext = creditNext + fetchPkg::creditType'(1);
        end
        if (creditRefund) begin
            creditNext = creditNext + fetchPkg::creditType'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc <= fetchPkg::RESET_PC;
            fetchId <= '0;
            creditCount <= fetchPkg::creditType'(fetchPkg::FETCH_CREDITS);
            issuedLast <= 1'b0;
            started <= 1'b0;
        end
        else begin
            fetchPc <= pcNext;
            creditCount <= creditNext;
            issuedLast <= issueValid;
            started <= 1'b1;
            if (issueValid) begin
                fetchId <= fetchId + fetchPkg::fetchIdType'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wfiActive <= 1'b0;
            wfiCount <= '0;
            intIssued <= 1'b0;
        end
        else begin
            if (wfiActive) begin
                wfiCount <= wfiCount - fetchPkg::wfiCountType'(1);
                if (interruptPending || wfiCount == '0) begin
                    wfiActive <= 1'b0;
                end
            end

            if (redirect) begin
                // Only a decode redirect can start a WFI pause.
                wfiActive <= !beRedirectValid && decRedirectWfi;
                wfiCount <= fetchPkg::wfiCountType'(fetchPkg::WFI_DELAY - 1);
                intIssued <= 1'b0;
            end
            else if (issueInterrupt) begin
                intIssued <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input wire clk,
    input wire rst,

    input wire beRedirectValid,
    input wire [fetchPkg::PC_WIDTH-1:0] beRedirectPc,
    input wire decRedirectValid,
    input wire [fetchPkg::PC_WIDTH-1:0] decRedirectPc,
    input wire decRedirectWfi,

    input wire interruptPending,
    input wire creditReturn,

    input wire btbUpdateValid,
    input wire [fetchPkg::PC_WIDTH-1:0] btbUpdateSrc,
    input wire [fetchPkg::PC_WIDTH-1:0] btbUpdateDst,
    input wire btbUpdateTaken,

    output logic imemReqValid,
    output logic [fetchPkg::PC_WIDTH-1:0] imemReqAddr,
    input wire [fetchPkg::INSTR_WIDTH-1:0] imemRespData,

    output logic outValid,
    output logic [fetchPkg::INSTR_WIDTH-1:0] outInstr,
    output logic [fetchPkg::PC_WIDTH-1:0] outPc,
    output logic [fetchPkg::FETCH_ID_WIDTH-1:0] outFetchId,
    output logic outPredTaken,
    output logic [fetchPkg::PC_WIDTH-1:0] outPredTarget,
    output logic outInterrupt,

    input wire [fetchPkg::FETCH_ID_WIDTH-1:0] pcReadAddr,
    output logic [fetchPkg::PC_WIDTH-1:0] pcReadData
);

    logic [fetchPkg::PC_WIDTH-1:0] fetchPc;
    logic issueValid;
    logic [fetchPkg::FETCH_ID_WIDTH-1:0] issueFetchId;
    logic issueInterrupt;
    logic squash;
    logic predTaken;
    logic [fetchPkg::PC_WIDTH-1:0] predTarget;

    assign imemReqValid = issueValid;
    assign imemReqAddr = fetchPc;

    fetchSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .beRedirectValid(beRedirectValid),
        .beRedirectPc(beRedirectPc),
        .decRedirectValid(decRedirectValid),
        .decRedirectPc(decRedirectPc),
        .decRedirectWfi(decRedirectWfi),
        .interruptPending(interruptPending),
        .creditReturn(creditReturn),
        .predTaken(predTaken),
        .predTarget(predTarget),
        .fetchPc(fetchPc),
        .issueValid(issueValid),
        .issueFetchId(issueFetchId),
        .issueInterrupt(issueInterrupt),
        .squash(squash)
    );

    // Prediction for the address being fetched now.
    branchTargetBuffer btb (
        .clk(clk),
        .rst(rst),
        .lookupPc(fetchPc),
        .predTaken(predTaken),
        .predTarget(predTarget),
        .updateValid(btbUpdateValid),
        .updateSrc(btbUpdateSrc),
        .updateDst(btbUpdateDst),
        .updateTaken(btbUpdateTaken)
    );

    imemTracker tracker (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issuePc(fetchPc),
        .issueFetchId(issueFetchId),
        .issueInterrupt(issueInterrupt),
        .issuePredTaken(predTaken),
        .issuePredTarget(predTarget),
        .squash(squash),
        .imemRespData(imemRespData),
        .outValid(outValid),
        .outInstr(outInstr),
        .outPc(outPc),
        .outFetchId(outFetchId),
        .outPredTaken(outPredTaken),
        .outPredTarget(outPredTarget),
        .outInterrupt(outInterrupt)
    );

    pcFile pcTable (
        .clk(clk),
        .writeValid(issueValid),
        .writeId(issueFetchId),
        .writePc(fetchPc),
        .readId(pcReadAddr),
        .readPc(pcReadData)
    );

endmodule

`default_nettype wire

/* sim/fetchUnit_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit_checker (
    input wire clk,
    input wire rst,
    input wire imemReqValid,
    input wire creditReturn,
    input wire beRedirectValid,
    input wire decRedirectValid,
    input wire outValid,
    input wire [fetchPkg::PC_WIDTH-1:0] outPc
);

    int failCount = 0;
    int outstanding;
    logic issuedLast;
    logic redirect;

    assign redirect = beRedirectValid || decRedirectValid;

    // Credits leave at issue and come back from decode or from a squash.
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
            issuedLast <= 1'b0;
        end
        else begin
            outstanding <= outstanding + int'(imemReqValid) - int'(creditReturn)
                - int'(redirect && issuedLast);
            issuedLast <= imemReqValid;
        end
    end

    resetQuiet: assert property (@(posedge clk) $fell(rst) |-> !outValid && !imemReqValid)
        else begin
            failCount++;
            $error("packet or fetch issued in the first cycle after reset");
        end

    alignedPc: assert property (@(posedge clk) disable iff (rst)
            outValid |-> outPc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("outPc is not word aligned");
        end

    creditBound: assert property (@(posedge clk) disable iff (rst)
            outstanding <= fetchPkg::FETCH_CREDITS)
        else begin
            failCount++;
            $error("more packets outstanding than decode can hold");
        end

    noIssueOnRedirect: assert property (@(posedge clk) disable iff (rst)
            redirect |-> !imemReqValid)
        else begin
            failCount++;
            $error("fetch issued in a redirect cycle");
        end

endmodule

`default_nettype wire

/* sim/fetchUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnitTb;

    localparam logic [31:0] MEM_KEY = 32'hA5A5_A5A5;
    // All phases together need a few hundred cycles.
    localparam int CYCLE_LIMIT = 2000;

    logic clk;
    logic rst;
    logic beRedirectValid;
    logic [31:0] beRedirectPc;
    logic decRedirectValid;
    logic [31:0] decRedirectPc;
    logic decRedirectWfi;
    logic interruptPending;
    logic creditReturn = 1'b0;
    logic btbUpdateValid;
    logic [31:0] btbUpdateSrc;
    logic [31:0] btbUpdateDst;
    logic btbUpdateTaken;
    logic imemReqValid;
    logic [31:0] imemReqAddr;
    logic [31:0] imemRespData = '0;
    logic outValid;
    logic [31:0] outInstr;
    logic [31:0] outPc;
    logic [fetchPkg::FETCH_ID_WIDTH-1:0] outFetchId;
    logic outPredTaken;
    logic [31:0] outPredTarget;
    logic outInterrupt;
    logic [fetchPkg::FETCH_ID_WIDTH-1:0] pcReadAddr = '0;
    logic [31:0] pcReadData;

    int cycleCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    int creditsReturned = 0;
    int checkedCount = 0;
    int intIndex = -1;
    // 0 random, 1 hold, 2 every cycle.
    int creditMode = 0;
    logic giveCredit = 1'b0;
    logic [31:0] rngState = 32'd2;
    logic memReq = 1'b0;
    logic [31:0] memAddr = '0;
    logic [31:0] pktPc [$];
    logic [31:0] pktInstr [$];
    logic [31:0] pktReadPc [$];
    logic [31:0] pktPredTarget [$];
    logic pktInt [$];
    logic pktPredTaken [$];
    int pktCycle [$];

    fetchUnit UUT (.*);

    bind fetchUnit fetchUnit_checker protocolCheck (
        .clk(clk),
        .rst(rst),
        .imemReqValid(imemReqValid),
        .creditReturn(creditReturn),
        .beRedirectValid(beRedirectValid),
        .decRedirectValid(decRedirectValid),
        .outValid(outValid),
        .outPc(outPc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Capture the memory request and log decode packets.
    always @(negedge clk) begin
        memReq = imemReqValid;
        memAddr = imemReqAddr;
        if (!rst && outValid) begin
            if (outInterrupt) begin
                intIndex = pktPc.size();
            end
            pktPc.push_back(outPc);
            pktInstr.push_back(outInstr);
            pktReadPc.push_back(pcReadData);
            pktPredTarget.push_back(outPredTarget);
            pktInt.push_back(outInterrupt);
            pktPredTaken.push_back(outPredTaken);
            pktCycle.push_back(cycleCount);
        end
    end

    // Memory response, PC file read and credit return.
    always @(posedge clk) begin
        cycleCount++;
        rngState = xorshift(rngState);
        giveCredit = pktPc.size() > creditsReturned && creditMode != 1
            && (creditMode == 2 || rngState[0]);
        if (giveCredit) begin
            creditsReturned++;
        end
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test did not finish", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
        else begin
            #1;
            imemRespData = memReq ? (memAddr ^ MEM_KEY) : '0;
            pcReadAddr = outFetchId;
            creditReturn = giveCredit;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            valueErrors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic checkCondition(input logic cond, input string what);
        assert (cond) else begin
            otherErrors++;
            $display("ERROR at time %0t: %s", $time, what);
        end
    endtask

    task automatic checkNewPackets();
        logic [31:0] expInstr;
        while (checkedCount < pktPc.size()) begin
            expInstr = pktInt[checkedCount] ? 32'h0 : (pktPc[checkedCount] ^ MEM_KEY);
            checkValue("outInstr", expInstr, pktInstr[checkedCount]);
            checkValue("pcReadData", pktPc[checkedCount], pktReadPc[checkedCount]);
            checkedCount++;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        checkNewPackets();
    endtask

    task automatic waitForPackets(input int count);
        while (pktPc.size() < count) begin
            nextCycle();
        end
    endtask

    task automatic expectSequence(input int first, input logic [31:0] startPc, input int count);
        waitForPackets(first + count);
        for (int i = 0; i < count; i++) begin
            checkValue("outPc", startPc + 32'(4 * i), pktPc[first + i]);
            checkValue("outInterrupt", 0, 32'(pktInt[first + i]));
        end
    endtask

    // Also applies any decode redirect or BTB update set up by the caller.
    task automatic redirectFromBackend(input logic [31:0] target, output int mark);
        beRedirectValid = 1'b1;
        beRedirectPc = target;
        mark = pktPc.size();
        nextCycle();
        beRedirectValid = 1'b0;
        decRedirectValid = 1'b0;
        decRedirectWfi = 1'b0;
        btbUpdateValid = 1'b0;
    endtask

    initial begin
        int mark;
        int redirectCycle;
        int checkerFails;
        rst = 1'b1;
        beRedirectValid = 1'b0;
        beRedirectPc = '0;
        decRedirectValid = 1'b0;
        decRedirectPc = '0;
        decRedirectWfi = 1'b0;
        interruptPending = 1'b0;
        btbUpdateValid = 1'b0;
        btbUpdateSrc = '0;
        btbUpdateDst = '0;
        btbUpdateTaken = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        expectSequence(0, fetchPkg::RESET_PC, 8);

        // Taken branch at 0x1008 to 0x2040, then cleared again.
        btbUpdateValid = 1'b1;
        btbUpdateSrc = 32'h0000_1008;
        btbUpdateDst = 32'h0000_2040;
        btbUpdateTaken = 1'b1;
        redirectFromBackend(32'h0000_1000, mark);
        expectSequence(mark, 32'h0000_1000, 3);
        checkValue("outPredTaken", 1, 32'(pktPredTaken[mark + 2]));
        checkValue("outPredTarget", 32'h0000_2040, pktPredTarget[mark + 2]);
        expectSequence(mark + 3, 32'h0000_2040, 2);
        btbUpdateValid = 1'b1;
        btbUpdateTaken = 1'b0;
        redirectFromBackend(32'h0000_1000, mark);
        expectSequence(mark, 32'h0000_1000, 4);
        checkValue("outPredTaken", 0, 32'(pktPredTaken[mark + 2]));

        // WFI pause, then run out of credits.
        creditMode = 2;
        decRedirectValid = 1'b1;
        decRedirectPc = 32'h0000_3000;
        decRedirectWfi = 1'b1;
        mark = pktPc.size();
        redirectCycle = cycleCount;
        nextCycle();
        decRedirectValid = 1'b0;
        decRedirectWfi = 1'b0;
        repeat (8) nextCycle();
        checkCondition(pktPc.size() == creditsReturned, "credits still held during WFI pause");
        checkCondition(pktPc.size() == mark, "a packet arrived during the WFI pause");
        creditMode = 1;
        waitForPackets(mark + 1);
        checkValue("first packet cycle", redirectCycle + fetchPkg::WFI_DELAY + 2, pktCycle[mark]);
        repeat (20) nextCycle();
        checkValue("packet count", fetchPkg::FETCH_CREDITS, pktPc.size() - mark);
        expectSequence(mark, 32'h0000_3000, fetchPkg::FETCH_CREDITS);
        creditMode = 0;
        expectSequence(mark + fetchPkg::FETCH_CREDITS,
                       32'h0000_3000 + 32'(4 * fetchPkg::FETCH_CREDITS), 2);

        redirectFromBackend(32'h0000_4000, mark);
        expectSequence(mark, 32'h0000_4000, 3);
        decRedirectValid = 1'b1;
        decRedirectPc = 32'h0000_6000;
        decRedirectWfi = 1'b1;
        redirectFromBackend(32'h0000_5000, mark);
        expectSequence(mark, 32'h0000_5000, 3);

        mark = pktPc.size();
        interruptPending = 1'b1;
        while (intIndex < 0) begin
            nextCycle();
        end
        checkCondition(intIndex >= mark, "interrupt packet came before the interrupt");
        repeat (20) nextCycle();
        checkValue("packet count", intIndex + 1, pktPc.size());
        interruptPending = 1'b0;
        repeat (10) nextCycle();
        checkValue("packet count", intIndex + 1, pktPc.size());
        redirectFromBackend(32'h0000_7000, mark);
        expectSequence(mark, 32'h0000_7000, 2);

        repeat (5) nextCycle();
        checkerFails = UUT.protocolCheck.failCount;
        $display("Errors: %0d value, %0d other, %0d checker", valueErrors, otherErrors,
                 checkerFails);
        if (valueErrors + otherErrors + checkerFails == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/fetchPkg.sv
source/branchTargetBuffer.sv
source/imemTracker.sv
source/pcFile.sv
source/fetchSequencer.sv
source/fetchUnit.sv
sim/fetchUnit_checker.sv
sim/fetchUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f files.f --top-module fetchUnitTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VfetchUnitTb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
